//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f sources.f --top-module tb_decode_top -o tb_decode_top
	./obj_dir/tb_decode_top

clean:
	rm -rf obj_dir

//--- hw/control_unit.sv
`timescale 1ns/1ps
`default_nettype none

module control_unit (
    input  rv_pkg::opcode_e op,
    output rv_pkg::ctrl_t   ctrl
);

    // start from a no-op bundle and set only what each opcode needs
    always_comb begin
        ctrl = '0;
        case (op)
            rv_pkg::OP_R: begin
                ctrl.reg_wr_en = 1'b1;
                ctrl.wb_sel    = rv_pkg::WB_ALU;
            end
            rv_pkg::OP_IMM: begin
                ctrl.reg_wr_en   = 1'b1;
                ctrl.imm_rs2_sel = 1'b1;
                ctrl.wb_sel      = rv_pkg::WB_ALU;
            end
            // address is rs1 + imm, data comes back from memory
            rv_pkg::OP_LOAD: begin
                ctrl.reg_wr_en   = 1'b1;
                ctrl.imm_rs2_sel = 1'b1;
                ctrl.wb_sel      = rv_pkg::WB_MEM;
            end
            // rs2 still travels as store data
            rv_pkg::OP_STORE: begin
                ctrl.mem_wr_en   = 1'b1;
                ctrl.imm_rs2_sel = 1'b1;
            end
            // alu compares rs1 and rs2, target adder uses pc + imm
            rv_pkg::OP_BRANCH: begin
                ctrl = '0;
            end
            // link value pc + 4 goes to rd
            rv_pkg::OP_JAL: begin
                ctrl.reg_wr_en       = 1'b1;
                ctrl.pc_rs1_sel      = 1'b1;
                ctrl.imm_rs2_sel     = 1'b1;
                ctrl.jump_branch_sel = 1'b1;
                ctrl.wb_sel          = rv_pkg::WB_PC4;
            end
            // target is rs1 + imm
            rv_pkg::OP_JALR: begin
                ctrl.reg_wr_en       = 1'b1;
                ctrl.imm_rs2_sel     = 1'b1;
                ctrl.jump_branch_sel = 1'b1;
                ctrl.wb_sel          = rv_pkg::WB_PC4;
            end
            // alu passes the immediate through
            rv_pkg::OP_LUI: begin
                ctrl.reg_wr_en   = 1'b1;
                ctrl.imm_rs2_sel = 1'b1;
                ctrl.wb_sel      = rv_pkg::WB_ALU;
            end
            rv_pkg::OP_AUIPC: begin
                ctrl.reg_wr_en   = 1'b1;
                ctrl.pc_rs1_sel  = 1'b1;
                ctrl.imm_rs2_sel = 1'b1;
                ctrl.wb_sel      = rv_pkg::WB_ALU;
            end
            // illegal opcode writes nothing anywhere
            default: begin
                ctrl = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hw/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_macros.svh"

module decode_stage (
    input  logic               clk,
    input  logic               rst,
    input  rv_pkg::fetch_pkt_t if_pkt,
    input  rv_pkg::wb_req_t    wb,
    output rv_pkg::id_ex_t     id_pkt
);

    logic [`RV_XLEN-1:0]       instr;
    rv_pkg::opcode_e           op;
    logic [`RV_REG_ADDR_W-1:0] rs1;
    logic [`RV_REG_ADDR_W-1:0] rs2;
    logic [`RV_XLEN-1:0]       imm;
    rv_pkg::ctrl_t             ctrl;
    logic [`RV_XLEN-1:0]       rs1_data;
    logic [`RV_XLEN-1:0]       rs2_data;

    assign instr = if_pkt.instr;

    // unknown opcodes pass through with their raw bits
    assign op  = rv_pkg::opcode_e'(instr[`RV_OP_FIELD]);
    assign rs1 = instr[`RV_RS1_FIELD];
    assign rs2 = instr[`RV_RS2_FIELD];

    imm_gen u_imm_gen (
        .instr (instr),
        .imm   (imm)
    );

    control_unit u_control_unit (
        .op   (op),
        .ctrl (ctrl)
    );

    // read the register fields even for formats that lack them
    // forwarding masks them later with pc_rs1_sel and imm_rs2_sel
    register_file u_register_file (
        .clk      (clk),
        .rst      (rst),
        .wb       (wb),
        .rs1_addr (rs1),
        .rs2_addr (rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    // assemble the ID/EX payload
    always_comb begin
        id_pkt.op       = op;
        id_pkt.funct3   = instr[`RV_FUNCT3_FIELD];
        id_pkt.funct7   = instr[`RV_FUNCT7_FIELD];
        id_pkt.rs1      = rs1;
        id_pkt.rs2      = rs2;
        id_pkt.rd       = instr[`RV_RD_FIELD];
        id_pkt.rs1_data = rs1_data;
        id_pkt.rs2_data = rs2_data;
        id_pkt.imm      = imm;
        id_pkt.pc       = if_pkt.pc;
        // link address for jal and jalr
        id_pkt.pc_4     = if_pkt.pc + `RV_XLEN'(4);
        id_pkt.ctrl     = ctrl;
    end

endmodule

`default_nettype wire

//--- hw/decode_top.sv
`timescale 1ns/1ps
`default_nettype none

module decode_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               flush,
    input  logic               in_valid,
    output logic               in_ready,
    input  rv_pkg::fetch_pkt_t in_pkt,
    input  rv_pkg::wb_req_t    wb,
    output logic               out_valid,
    input  logic               out_ready,
    output rv_pkg::id_ex_t     out_pkt
);

    // IF/ID to decode handshake
    logic               if_id_valid;
    logic               if_id_ready;
    rv_pkg::fetch_pkt_t if_id_pkt;
    // decoded payload into ID/EX
    rv_pkg::id_ex_t     id_pkt;

    pipe_reg #(
        .payload_t (rv_pkg::fetch_pkt_t)
    ) u_if_id (
        .clk       (clk),
        .rst       (rst),
        .flush     (flush),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_pkt),
        .out_valid (if_id_valid),
        .out_ready (if_id_ready),
        .out_data  (if_id_pkt)
    );

    // register data is sampled here, when the item enters ID/EX
    decode_stage u_decode (
        .clk    (clk),
        .rst    (rst),
        .if_pkt (if_id_pkt),
        .wb     (wb),
        .id_pkt (id_pkt)
    );

    pipe_reg #(
        .payload_t (rv_pkg::id_ex_t)
    ) u_id_ex (
        .clk       (clk),
        .rst       (rst),
        .flush     (flush),
        .in_valid  (if_id_valid),
        .in_ready  (if_id_ready),
        .in_data   (id_pkt),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_pkt)
    );

endmodule

`default_nettype wire

//--- hw/imm_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_macros.svh"

module imm_gen (
    input  logic [`RV_XLEN-1:0] instr,
    output logic [`RV_XLEN-1:0] imm
);

    logic [6:0] op;

    assign op = instr[`RV_OP_FIELD];

    // format follows the major opcode
    // instr[31] is the sign bit in every format
    always_comb begin
        case (op)
            // I format
            rv_pkg::OP_IMM,
            rv_pkg::OP_LOAD,
            rv_pkg::OP_JALR: begin
                imm = {{20{instr[31]}}, instr[31:20]};
            end
            // S format, offset split around rs2
            rv_pkg::OP_STORE: begin
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            // B format, halfword aligned offset
            rv_pkg::OP_BRANCH: begin
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                       instr[11:8], 1'b0};
            end
            // U format fills the upper 20 bits
            rv_pkg::OP_LUI,
            rv_pkg::OP_AUIPC: begin
                imm = {instr[31:12], 12'b0};
            end
            // J format, 21 bit halfword offset
            rv_pkg::OP_JAL: begin
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                       instr[30:21], 1'b0};
            end
            // R format and anything unknown carry no immediate
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hw/pipe_reg.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     flush,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    logic     valid_q;
    payload_t data_q;

    // accept when empty or when the held item leaves this cycle
    // a flush empties the slot, so upstream is never stalled by it
    assign in_ready = !valid_q || out_ready || flush;

    // flush wins over any load on the same edge
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            valid_q <= 1'b0;
        end else if (in_ready) begin
            valid_q <= in_valid;
        end
    end

    // payload only moves on a real transfer
    always_ff @(posedge clk) begin
        if (in_valid && in_ready && !flush) begin
            data_q <= in_data;
        end
    end

    assign out_valid = valid_q;
    assign out_data  = data_q;

    // a stalled item must hold its payload until taken or flushed
    assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready && !flush |=> $stable(out_data))
        else $error("pipe_reg: payload changed while stalled");

endmodule

`default_nettype wire

//--- hw/register_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_macros.svh"

module register_file (
    input  logic                      clk,
    input  logic                      rst,
    input  rv_pkg::wb_req_t           wb,
    input  logic [`RV_REG_ADDR_W-1:0] rs1_addr,
    input  logic [`RV_REG_ADDR_W-1:0] rs2_addr,
    output logic [`RV_XLEN-1:0]       rs1_data,
    output logic [`RV_XLEN-1:0]       rs2_data
);

    // x0 has no storage
    logic [`RV_XLEN-1:0] regs [1:`RV_REG_COUNT-1];

    // writes to x0 are dropped
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < `RV_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.en && wb.addr != '0) begin
            regs[wb.addr] <= wb.data;
        end
    end

    // one read port
    // same-cycle write to the address is bypassed to the reader
    function automatic logic [`RV_XLEN-1:0] read_port(
        input logic [`RV_REG_ADDR_W-1:0] addr
    );
        if (addr == '0) begin
            return '0;
        end
        if (wb.en && wb.addr == addr) begin
            return wb.data;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rs1_data = read_port(rs1_addr);
        rs2_data = read_port(rs2_addr);
    end

    // a written value is seen on the next cycle unless overwritten again
    assert property (@(posedge clk) disable iff (rst)
        wb.en && wb.addr != '0 |=> rs1_addr != $past(wb.addr)
            || (wb.en && wb.addr == rs1_addr) || rs1_data == $past(wb.data))
        else $error("register_file: written value lost");

endmodule

`default_nettype wire

//--- hw/rv_pkg.sv
`default_nettype none

`include "rv_macros.svh"

package rv_pkg;

    // RV32I major opcodes handled by decode
    typedef enum logic [6:0] {
        OP_R      = 7'b0110011,
        OP_IMM    = 7'b0010011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111
    } opcode_e;

    // source of the value written back to rd
    typedef enum logic [1:0] {
        WB_ALU = 2'd0,
        WB_MEM = 2'd1,
        WB_PC4 = 2'd2
    } wb_sel_e;

    // control bundle carried into execute and beyond
    typedef struct packed {
        // alu operand a is the pc instead of rs1
        logic    pc_rs1_sel;
        // alu operand b is the immediate instead of rs2
        logic    imm_rs2_sel;
        // target adder result is a jump, not a conditional branch
        logic    jump_branch_sel;
        logic    mem_wr_en;
        logic    reg_wr_en;
        wb_sel_e wb_sel;
    } ctrl_t;

    // packet from fetch into the IF/ID register
    typedef struct packed {
        logic [`RV_XLEN-1:0] pc;
        logic [`RV_XLEN-1:0] instr;
    } fetch_pkt_t;

    // decoded item held in the ID/EX register
    typedef struct packed {
        opcode_e                   op;
        logic [2:0]                funct3;
        logic [6:0]                funct7;
        // raw indices kept for a later forwarding unit
        logic [`RV_REG_ADDR_W-1:0] rs1;
        logic [`RV_REG_ADDR_W-1:0] rs2;
        logic [`RV_REG_ADDR_W-1:0] rd;
        logic [`RV_XLEN-1:0]       rs1_data;
        logic [`RV_XLEN-1:0]       rs2_data;
        logic [`RV_XLEN-1:0]       imm;
        logic [`RV_XLEN-1:0]       pc;
        logic [`RV_XLEN-1:0]       pc_4;
        ctrl_t                     ctrl;
    } id_ex_t;

    // write-back request into the register file
    typedef struct packed {
        logic                      en;
        logic [`RV_REG_ADDR_W-1:0] addr;
        logic [`RV_XLEN-1:0]       data;
    } wb_req_t;

endpackage

`default_nettype wire

//--- include/rv_macros.svh
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// datapath and address width
`define RV_XLEN 32

// architectural integer registers, x0 included
`define RV_REG_COUNT 32

// bits needed to name one register
`define RV_REG_ADDR_W 5

// instruction field positions shared by all RV32I formats
// major opcode
`define RV_OP_FIELD 6:0

// destination register
`define RV_RD_FIELD 11:7

// minor opcode
`define RV_FUNCT3_FIELD 14:12

// first source register
`define RV_RS1_FIELD 19:15

// second source register
`define RV_RS2_FIELD 24:20

// R-type function extension (sub/sra select)
`define RV_FUNCT7_FIELD 31:25

`endif

//--- sources.f
+incdir+include
hw/rv_pkg.sv
hw/pipe_reg.sv
hw/imm_gen.sv
hw/control_unit.sv
hw/register_file.sv
hw/decode_stage.sv
hw/decode_top.sv
test/tb_decode_top.sv

//--- test/tb_decode_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_macros.svh"

module tb_decode_top;

    // item budget per test, the watchdog allows 20 cycles for each
    localparam int T1_WRITES = 32;
    localparam int T1_ITEMS = 16;
    localparam int T2_ITEMS = 27;
    localparam int T3_ITEMS = 10;
    localparam int T4_ITEMS = 40;
    localparam int T4_HOLD = 3;
    localparam int T5_ITEMS = 4;
    localparam int T6_ITEMS = 3;
    localparam int N_ITEMS = T1_WRITES + T1_ITEMS + T2_ITEMS + T3_ITEMS + T4_ITEMS
                             + T4_HOLD + T5_ITEMS + T6_ITEMS;

    logic               clk;
    logic               rst;
    logic               flush;
    logic               in_valid;
    logic               in_ready;
    rv_pkg::fetch_pkt_t in_pkt;
    rv_pkg::wb_req_t    wb;
    logic               out_valid;
    logic               out_ready;
    rv_pkg::id_ex_t     out_pkt;

    // model state
    logic [`RV_XLEN-1:0] shadow [0:`RV_REG_COUNT-1];
    logic [31:0]         lcg_state;
    rv_pkg::id_ex_t      last_out;

    decode_top u_decode_top (
        .clk       (clk),
        .rst       (rst),
        .flush     (flush),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_pkt    (in_pkt),
        .wb        (wb),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_pkt   (out_pkt)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // index 9 and above give an opcode outside RV32I
    function automatic logic [6:0] opcode_at(input int i);
        case (i)
            0: return rv_pkg::OP_R;
            1: return rv_pkg::OP_IMM;
            2: return rv_pkg::OP_LOAD;
            3: return rv_pkg::OP_STORE;
            4: return rv_pkg::OP_BRANCH;
            5: return rv_pkg::OP_JAL;
            6: return rv_pkg::OP_JALR;
            7: return rv_pkg::OP_LUI;
            8: return rv_pkg::OP_AUIPC;
            default: return 7'b1111111;
        endcase
    endfunction

    // immediate per ISA format, sign taken from bit 31
    function automatic logic [31:0] model_imm(input logic [31:0] w);
        logic [31:0] sx;
        sx = {{20{w[31]}}, w[31:20]};
        case (w[6:0])
            7'b0010011, 7'b0000011, 7'b1100111: return sx;
            7'b0100011: return {sx[31:5], w[11:7]};
            7'b1100011: return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            7'b0110111, 7'b0010111: return {w[31:12], 12'h000};
            7'b1101111: return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            default: return 32'h0;
        endcase
    endfunction

    function automatic rv_pkg::ctrl_t make_ctrl(input logic pc_a, input logic imm_b,
                                                input logic jump, input logic mem_wr,
                                                input logic reg_wr,
                                                input rv_pkg::wb_sel_e sel);
        rv_pkg::ctrl_t c;
        c.pc_rs1_sel = pc_a;
        c.imm_rs2_sel = imm_b;
        c.jump_branch_sel = jump;
        c.mem_wr_en = mem_wr;
        c.reg_wr_en = reg_wr;
        c.wb_sel = sel;
        return c;
    endfunction

    // control table, unknown opcodes write nothing
    function automatic rv_pkg::ctrl_t model_ctrl(input logic [6:0] op);
        case (op)
            rv_pkg::OP_R:      return make_ctrl(0, 0, 0, 0, 1, rv_pkg::WB_ALU);
            rv_pkg::OP_IMM:    return make_ctrl(0, 1, 0, 0, 1, rv_pkg::WB_ALU);
            rv_pkg::OP_LOAD:   return make_ctrl(0, 1, 0, 0, 1, rv_pkg::WB_MEM);
            rv_pkg::OP_STORE:  return make_ctrl(0, 1, 0, 1, 0, rv_pkg::WB_ALU);
            rv_pkg::OP_JAL:    return make_ctrl(1, 1, 1, 0, 1, rv_pkg::WB_PC4);
            rv_pkg::OP_JALR:   return make_ctrl(0, 1, 1, 0, 1, rv_pkg::WB_PC4);
            rv_pkg::OP_LUI:    return make_ctrl(0, 1, 0, 0, 1, rv_pkg::WB_ALU);
            rv_pkg::OP_AUIPC:  return make_ctrl(1, 1, 0, 0, 1, rv_pkg::WB_ALU);
            default:           return make_ctrl(0, 0, 0, 0, 0, rv_pkg::WB_ALU);
        endcase
    endfunction

    // expected ID/EX item, register data from the shadow array as it stands now
    function automatic rv_pkg::id_ex_t model_item(input rv_pkg::fetch_pkt_t p);
        rv_pkg::id_ex_t e;
        e.op = rv_pkg::opcode_e'(p.instr[6:0]);
        e.funct3 = p.instr[14:12];
        e.funct7 = p.instr[31:25];
        e.rs1 = p.instr[19:15];
        e.rs2 = p.instr[24:20];
        e.rd = p.instr[11:7];
        e.rs1_data = shadow[p.instr[19:15]];
        e.rs2_data = shadow[p.instr[24:20]];
        e.imm = model_imm(p.instr);
        e.pc = p.pc;
        e.pc_4 = p.pc + 32'd4;
        e.ctrl = model_ctrl(p.instr[6:0]);
        return e;
    endfunction

    function automatic rv_pkg::fetch_pkt_t random_pkt(input logic [6:0] op);
        rv_pkg::fetch_pkt_t p;
        logic [31:0] rnd;
        rnd = lcg_next();
        p.instr = {rnd[31:7], op};
        rnd = lcg_next();
        p.pc = {rnd[31:2], 2'b00};
        return p;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_word(input string name, input logic [`RV_XLEN-1:0] got,
                              input logic [`RV_XLEN-1:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_ctrl(input string name, input rv_pkg::ctrl_t got,
                              input rv_pkg::ctrl_t exp);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_id_ex(input string name, input rv_pkg::id_ex_t got,
                               input rv_pkg::id_ex_t exp);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
        end
    endtask

    // all bus tasks start and end 1 ns after a rising edge
    // handshakes are sampled at the falling edge where everything is settled
    task automatic send_item(input rv_pkg::fetch_pkt_t p);
        logic taken;
        taken = 1'b0;
        in_valid = 1'b1;
        in_pkt = p;
        while (!taken) begin
            @(negedge clk);
            taken = in_ready;
            @(posedge clk);
            #1;
        end
        in_valid = 1'b0;
    endtask

    task automatic receive_item(input rv_pkg::id_ex_t exp, input logic toggle_ready);
        logic taken;
        logic [31:0] rnd;
        taken = 1'b0;
        while (!taken) begin
            rnd = lcg_next();
            out_ready = toggle_ready ? rnd[16] : 1'b1;
            @(negedge clk);
            taken = out_valid && out_ready;
            if (taken) begin
                last_out = out_pkt;
                check_id_ex("out_pkt", out_pkt, exp);
            end
            @(posedge clk);
            #1;
        end
        out_ready = 1'b0;
    endtask

    task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
        wb.en = 1'b1;
        wb.addr = addr;
        wb.data = data;
        @(posedge clk);
        #1;
        wb.en = 1'b0;
        // x0 stays zero in the model too
        if (addr != 5'd0) begin
            shadow[addr] = data;
        end
    endtask

    // nothing may leave the pipe for a while
    task automatic expect_idle(input int cycles);
        out_ready = 1'b1;
        repeat (cycles) begin
            @(negedge clk);
            if (out_valid) begin
                abort_run("an item left the pipe when none was expected");
            end
            @(posedge clk);
            #1;
        end
        out_ready = 1'b0;
    endtask

    task automatic test_register_reads();
        rv_pkg::fetch_pkt_t p;
        logic [31:0] rnd;
        logic [4:0] a;
        logic [4:0] b;
        for (int r = 0; r < T1_WRITES; r++) begin
            write_reg(5'(r), lcg_next());
        end
        for (int i = 0; i < T1_ITEMS; i++) begin
            rnd = lcg_next();
            // first two items read x0 on one port
            a = (i == 0) ? 5'd0 : rnd[19:15];
            b = (i == 1) ? 5'd0 : rnd[24:20];
            p = random_pkt(rv_pkg::OP_R);
            p.instr = {rnd[31:25], b, a, rnd[14:12], rnd[11:7], p.instr[6:0]};
            send_item(p);
            receive_item(model_item(p), 1'b0);
            check_word("rs1_data", last_out.rs1_data, shadow[a]);
            check_word("rs2_data", last_out.rs2_data, shadow[b]);
        end
    endtask

    task automatic test_immediates();
        rv_pkg::fetch_pkt_t p;
        for (int i = 0; i < T2_ITEMS; i++) begin
            p = random_pkt(opcode_at(i % 9));
            send_item(p);
            receive_item(model_item(p), 1'b0);
            check_word("imm", last_out.imm, model_imm(p.instr));
            check_word("pc_4", last_out.pc_4, p.pc + 32'd4);
        end
    endtask

    task automatic test_control_table();
        rv_pkg::fetch_pkt_t p;
        for (int i = 0; i < T3_ITEMS; i++) begin
            p = random_pkt(opcode_at(i));
            send_item(p);
            receive_item(model_item(p), 1'b0);
            check_ctrl("ctrl", last_out.ctrl, model_ctrl(opcode_at(i)));
        end
    endtask

    task automatic test_back_pressure();
        rv_pkg::fetch_pkt_t pkts [$];
        rv_pkg::id_ex_t exps [$];
        logic [31:0] rnd;
        int accepted;
        // stream built up front so both sides see the same order
        for (int i = 0; i < T4_ITEMS + T4_HOLD; i++) begin
            rnd = lcg_next();
            pkts.push_back(random_pkt(opcode_at(int'(rnd % 32'd9))));
            exps.push_back(model_item(pkts[i]));
        end
        fork
            begin
                for (int i = 0; i < T4_ITEMS; i++) send_item(pkts[i]);
            end
            begin
                for (int i = 0; i < T4_ITEMS; i++) receive_item(exps[i], 1'b1);
            end
        join
        expect_idle(4);
        // execute stalled, only IF/ID and ID/EX can take items
        accepted = 0;
        in_valid = 1'b1;
        in_pkt = pkts[T4_ITEMS];
        repeat (10) begin
            @(negedge clk);
            if (in_ready) accepted++;
            @(posedge clk);
            #1;
            if (accepted < T4_HOLD) in_pkt = pkts[T4_ITEMS + accepted];
        end
        check_word("accepted_while_stalled", accepted, 32'd2);
        fork
            send_item(pkts[T4_ITEMS + 2]);
            begin
                for (int i = 0; i < T4_HOLD; i++) receive_item(exps[T4_ITEMS + i], 1'b0);
            end
        join
        expect_idle(4);
    endtask

    task automatic test_flush();
        rv_pkg::fetch_pkt_t p;
        out_ready = 1'b0;
        send_item(random_pkt(rv_pkg::OP_IMM));
        send_item(random_pkt(rv_pkg::OP_LOAD));
        check_word("out_valid", 32'(out_valid), 32'd1);
        // a third item offered on the flush edge is dropped
        in_valid = 1'b1;
        in_pkt = random_pkt(rv_pkg::OP_JAL);
        flush = 1'b1;
        @(negedge clk);
        if (!in_ready) begin
            abort_run("in_ready was low while flush was asserted");
        end
        @(posedge clk);
        #1;
        flush = 1'b0;
        in_valid = 1'b0;
        expect_idle(6);
        p = random_pkt(rv_pkg::OP_STORE);
        send_item(p);
        receive_item(model_item(p), 1'b0);
    endtask

    task automatic test_write_bypass();
        rv_pkg::fetch_pkt_t pf;
        rv_pkg::fetch_pkt_t px;
        rv_pkg::id_ex_t exp_f;
        logic [31:0] v1;
        logic [31:0] v2;
        pf = random_pkt(rv_pkg::OP_AUIPC);
        px = random_pkt(rv_pkg::OP_R);
        // x reads rs1 = x5 and rs2 = x6
        px.instr[24:15] = {5'd6, 5'd5};
        exp_f = model_item(pf);
        out_ready = 1'b0;
        send_item(pf);
        send_item(px);
        v1 = lcg_next();
        v2 = lcg_next();
        // late write while x sits in IF/ID
        write_reg(5'd5, v1);
        // x6 written on the same edge that moves x into ID/EX
        wb.en = 1'b1;
        wb.addr = 5'd6;
        wb.data = v2;
        out_ready = 1'b1;
        @(negedge clk);
        if (!out_valid) begin
            abort_run("the older item was missing at the output");
        end
        check_id_ex("out_pkt", out_pkt, exp_f);
        @(posedge clk);
        #1;
        wb.en = 1'b0;
        out_ready = 1'b0;
        shadow[6] = v2;
        receive_item(model_item(px), 1'b0);
        check_word("rs1_data", last_out.rs1_data, v1);
        check_word("rs2_data", last_out.rs2_data, v2);
    endtask

    initial begin
        repeat (8 + 20 * N_ITEMS) @(posedge clk);
        abort_run("timeout, the tests did not finish within the cycle budget");
    end

    initial begin
        rst = 1'b1;
        flush = 1'b0;
        in_valid = 1'b0;
        in_pkt = '0;
        wb = '0;
        out_ready = 1'b0;
        last_out = '0;
        lcg_state = 32'hdd10d585;
        for (int i = 0; i < `RV_REG_COUNT; i++) shadow[i] = '0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        test_register_reads();
        test_immediates();
        test_control_table();
        test_back_pressure();
        test_flush();
        test_write_bypass();
        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire
